/* Makefile */
sim:
	verilator --binary --timing --timescale 1ns/10ps -f files.f \
		--top-module fetch_frontend_tb -o fetch_sim
	./obj_dir/fetch_sim | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* dv/fetch_frontend_tb.sv */
`timescale 1ns/10ps

module fetch_frontend_tb;

    // Stream start points with upper bits set so the full inst_pc is exercised
    localparam logic [47:0] boot_pc     = 48'hC001_1234_5600;
    localparam logic [47:0] branch_pc   = 48'h5A5A_7654_3224;   // Word 9 of its line
    localparam logic [47:0] irq_pc      = 48'hFFFF_0ABC_1F38;   // Two words before line end
    localparam logic [47:0] other_pc    = 48'h3C3C_0111_2200;   // Branch that must lose
    localparam logic [47:0] flight_pc_a = 48'h8888_0033_3300;
    localparam logic [47:0] flight_pc_b = 48'h0F0F_0044_4448;

    // Transfers per test and the run limit
    localparam int n_boot          = 64;
    localparam int n_branch        = 40;
    localparam int n_irq           = 40;
    localparam int n_flight        = 40;
    localparam int n_stress        = 256;
    localparam int total_insts     = n_boot + n_branch + n_irq + 2 * n_flight + n_stress;
    localparam int expected_cycles = 16 + 2 * total_insts + 6 * 60;  // Plus refill per redirect
    localparam int timeout_cycles  = 8 * expected_cycles;

    logic                          clk = 1'b0;
    logic                          rst_n = 1'b0;
    logic [fetch_pkg::addr_w-1:0]  boot_addr = boot_pc;
    logic                          interrupt_valid = 1'b0;
    logic [fetch_pkg::addr_w-1:0]  interrupt_addr = '0;
    logic                          branch_addr_valid = 1'b0;
    logic [fetch_pkg::addr_w-1:0]  branch_addr = '0;
    logic                          mem_req_valid;
    logic [fetch_pkg::index_w-1:0] mem_req_index;
    logic                          mem_req_ready = 1'b0;
    logic                          mem_beat_valid = 1'b0;
    logic [fetch_pkg::beat_w-1:0]  mem_beat_data = '0;
    logic                          inst_valid;
    logic [fetch_pkg::inst_w-1:0]  inst_data;
    logic [fetch_pkg::addr_w-1:0]  inst_pc;
    logic                          inst_ready = 1'b0;

    string       test_name = "boot";
    logic [31:0] lcg_state = 32'd68;     // Stall generator state
    int          beats_left = 0;         // Beats still owed by the memory
    logic [19:0] mem_word_ptr = '0;      // Word address of the next beat
    logic        random_ready = 1'b0;
    int          hold_seq = 0;           // Bumped per redirect and seen by the driver
    int          hold_seen = 0;
    int          hold_left = 0;
    int          redirect_seq = 0;       // Bumped per redirect and seen by the checker
    int          seen_seq = 0;
    logic [47:0] redirect_target = '0;
    logic [47:0] exp_pc = '0;            // Reference PC tracker
    int          xfer_count = 0;
    int          errors = 0;
    int          checks = 0;
    int          reset_edges = 0;
    int          cycle_count = 0;
    logic        held = 1'b0;            // Offer stalled at the last edge
    logic [31:0] held_data = '0;
    logic [47:0] held_pc = '0;

    fetch_frontend UUT (
        .clk               (clk),
        .rst_n             (rst_n),
        .boot_addr         (boot_addr),
        .interrupt_valid   (interrupt_valid),
        .interrupt_addr    (interrupt_addr),
        .branch_addr_valid (branch_addr_valid),
        .branch_addr       (branch_addr),
        .mem_req_valid     (mem_req_valid),
        .mem_req_index     (mem_req_index),
        .mem_req_ready     (mem_req_ready),
        .mem_beat_valid    (mem_beat_valid),
        .mem_beat_data     (mem_beat_data),
        .inst_valid        (inst_valid),
        .inst_data         (inst_data),
        .inst_pc           (inst_pc),
        .inst_ready        (inst_ready)
    );

    always #10 clk = ~clk;               // 20 ns period

    // Next value of the stall generator
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Memory word for byte address bits 21:2
    // Odd multiply keeps every address distinct
    function automatic logic [31:0] mem_word(input logic [19:0] word_addr);
        return ({12'h000, word_addr} * 32'h9E37_79B1) ^ 32'hA5C3_0F69;
    endfunction

    // Expected instruction at a fetch address
    // Memory decodes bits 21:2 only
    function automatic logic [31:0] expected_inst(input logic [47:0] addr);
        return mem_word(addr[21:2]);
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("mismatch %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // Memory model and inst_ready driver
    always @(posedge clk) begin
        if (mem_req_valid && mem_req_ready) begin
            mem_word_ptr = {mem_req_index[18:3], 4'b0000};   // Line base in word units
            beats_left   = fetch_pkg::beats_per_line;
        end
        if (mem_beat_valid) begin
            mem_word_ptr = mem_word_ptr + 20'd2;             // Two words per beat
            beats_left   = beats_left - 1;
        end
        #1;
        lcg_state     = lcg_next(lcg_state);
        mem_req_ready = (lcg_state[31:30] != 2'b00);         // Ready three times in four
        if (beats_left > 0 && lcg_state[29:28] != 2'b00) begin
            mem_beat_valid = 1'b1;
            mem_beat_data  = {mem_word(mem_word_ptr + 20'd1), mem_word(mem_word_ptr)};
        end else begin
            mem_beat_valid = 1'b0;                            // Random gap or idle
            mem_beat_data  = '0;
        end
        if (hold_seq != hold_seen) begin
            hold_seen = hold_seq;
            hold_left = 4;                                    // Redirect cycle and three more
        end
        if (hold_left > 0) begin
            inst_ready = 1'b0;
            hold_left  = hold_left - 1;
        end else begin
            inst_ready = random_ready ? (lcg_state[27:26] != 2'b00) : 1'b1;
        end
    end

    // Checker for every transfer and for stalled offers
    always @(posedge clk) begin
        if (!rst_n) begin
            if (reset_edges > 0) begin
                check_value("reset inst_valid", 64'd0, 64'(inst_valid));
            end
            reset_edges++;
            exp_pc = boot_pc;
            held   = 1'b0;
        end else begin
            if (redirect_seq != seen_seq) begin
                seen_seq = redirect_seq;
                exp_pc   = redirect_target;                   // Stream restarts here
            end
            if (held && inst_valid) begin
                check_value({test_name, " held inst_data"}, 64'(held_data), 64'(inst_data));
                check_value({test_name, " held inst_pc"}, 64'(held_pc), 64'(inst_pc));
            end
            if (inst_valid && inst_ready) begin
                check_value({test_name, " inst_pc"}, 64'(exp_pc), 64'(inst_pc));
                check_value({test_name, " inst_data"}, 64'(expected_inst(exp_pc)),
                            64'(inst_data));
                exp_pc = exp_pc + 48'd4;                      // Next word address
                xfer_count++;
            end
            held      = inst_valid && !inst_ready;
            held_data = inst_data;
            held_pc   = inst_pc;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_cycles) begin
            $display("Timeout after %0d cycles, only %0d transfers seen in test %s",
                     cycle_count, xfer_count, test_name);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic wait_transfers(input int n);
        int target;
        target = xfer_count + n;
        while (xfer_count < target) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Some beats in and several still to come
    task automatic wait_read_in_flight();
        while (beats_left < 4 || beats_left > 6) begin
            @(posedge clk);
            #1;
        end
    endtask

    // One-cycle redirect with inst_ready held low around it
    task automatic apply_redirect(input logic irq, input logic [47:0] irq_addr,
                                  input logic br, input logic [47:0] br_addr,
                                  input logic [47:0] target);
        @(posedge clk);
        hold_seq++;
        #1;
        interrupt_valid   = irq;
        interrupt_addr    = irq_addr;
        branch_addr_valid = br;
        branch_addr       = br_addr;
        redirect_target   = target;
        redirect_seq++;
        @(posedge clk);
        #1;
        interrupt_valid   = 1'b0;
        branch_addr_valid = 1'b0;
    endtask

    initial begin
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        wait_transfers(n_boot);

        test_name = "branch";
        apply_redirect(1'b0, '0, 1'b1, branch_pc, branch_pc);
        wait_transfers(n_branch);

        test_name = "interrupt";
        apply_redirect(1'b1, irq_pc, 1'b1, other_pc, irq_pc);   // Interrupt outranks branch
        wait_transfers(n_irq);

        test_name = "in_flight";
        wait_read_in_flight();
        apply_redirect(1'b0, '0, 1'b1, flight_pc_a, flight_pc_a);
        wait_transfers(n_flight);
        wait_read_in_flight();
        apply_redirect(1'b0, '0, 1'b1, flight_pc_b, flight_pc_b);
        wait_transfers(n_flight);

        test_name = "backpressure";
        @(posedge clk);
        random_ready = 1'b1;
        #1;
        wait_transfers(n_stress);

        $display("Checks: %0d, transfers: %0d, errors: %0d", checks, xfer_count, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* files.f */
hw/fetch_pkg.sv
hw/fetch_req_if.sv
hw/ibuf_ctrl_if.sv
hw/pc_ctrl.sv
hw/line_fetch.sv
hw/inst_buffer.sv
hw/fetch_frontend.sv
dv/fetch_frontend_tb.sv

/* hw/fetch_frontend.sv */
`timescale 1ns/10ps

module fetch_frontend (
    input  logic                          clk,
    input  logic                          rst_n,

    // Redirect sources
    input  logic [fetch_pkg::addr_w-1:0]  boot_addr,
    input  logic                          interrupt_valid,
    input  logic [fetch_pkg::addr_w-1:0]  interrupt_addr,
    input  logic                          branch_addr_valid,
    input  logic [fetch_pkg::addr_w-1:0]  branch_addr,

    // External memory channel
    output logic                          mem_req_valid,
    output logic [fetch_pkg::index_w-1:0] mem_req_index,
    input  logic                          mem_req_ready,
    input  logic                          mem_beat_valid,
    input  logic [fetch_pkg::beat_w-1:0]  mem_beat_data,

    // Instruction stream toward the core
    output logic                          inst_valid,
    output logic [fetch_pkg::inst_w-1:0]  inst_data,
    output logic [fetch_pkg::addr_w-1:0]  inst_pc,
    input  logic                          inst_ready
);

    fetch_req_if u_req_if ();   // Line request group
    ibuf_ctrl_if u_ctrl_if ();  // Buffer control group

    // Gathered line from the memory stage to the buffer
    logic [fetch_pkg::beat_w*fetch_pkg::beats_per_line-1:0] line_data;

    pc_ctrl u_pc_ctrl (
        .clk               (clk),
        .rst_n             (rst_n),
        .boot_addr         (boot_addr),
        .interrupt_valid   (interrupt_valid),
        .interrupt_addr    (interrupt_addr),
        .branch_addr_valid (branch_addr_valid),
        .branch_addr       (branch_addr),
        .req               (u_req_if.pc_side),
        .ctrl              (u_ctrl_if.pc_side)
    );

    line_fetch u_line_fetch (
        .clk            (clk),
        .rst_n          (rst_n),
        .req            (u_req_if.mem_side),
        .mem_req_valid  (mem_req_valid),
        .mem_req_index  (mem_req_index),
        .mem_req_ready  (mem_req_ready),
        .mem_beat_valid (mem_beat_valid),
        .mem_beat_data  (mem_beat_data),
        .line_data      (line_data)
    );

    inst_buffer u_inst_buffer (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (u_ctrl_if.buf_side),
        .line_data  (line_data),
        .inst_valid (inst_valid),
        .inst_data  (inst_data),
        .inst_pc    (inst_pc),
        .inst_ready (inst_ready)
    );

endmodule

/* hw/fetch_pkg.sv */
package fetch_pkg;

    // Address space of the core
    localparam int addr_w = 48;            // PC and all redirect targets
    localparam int index_w = 19;           // Memory index is PC[21:3]

    // Line geometry
    localparam int line_bytes = 64;        // One fetch line and the sequential step
    localparam int beat_w = 64;            // One memory data beat
    localparam int beats_per_line = 8;     // Beats per accepted read

    // Instruction geometry
    localparam int inst_w = 32;
    localparam int words_per_line = 16;    // Instructions held by one line

    // Program counter stage
    typedef enum logic [0:0] {
        PC_BOOT,                           // First cycle out of reset
        PC_RUN                             // Normal operation
    } pc_state_e;

    // Memory channel stage
    typedef enum logic [1:0] {
        LF_IDLE,                           // Ready for a new line index
        LF_REQ,                            // Index offered to memory
        LF_BEATS                           // Collecting returned beats
    } lf_state_e;

endpackage

/* hw/fetch_req_if.sv */
`timescale 1ns/10ps

// Line read request between the PC stage and the memory channel stage
interface fetch_req_if;

    logic                          req_valid;   // Index is waiting for line_fetch
    logic [fetch_pkg::index_w-1:0] req_index;   // PC[21:3] of the line to read
    logic                          req_flush;   // One-cycle pulse on redirect
    logic                          req_ready;   // line_fetch is idle
    logic                          req_done;    // Whole line stored

    // PC side issues indexes and flushes
    modport pc_side (
        output req_valid,
        output req_index,
        output req_flush,
        input  req_ready,
        input  req_done
    );

    // Memory side accepts indexes and reports completion
    modport mem_side (
        input  req_valid,
        input  req_index,
        input  req_flush,
        output req_ready,
        output req_done
    );

endinterface

/* hw/ibuf_ctrl_if.sv */
`timescale 1ns/10ps

// Buffer control between the PC stage and the instruction buffer
interface ibuf_ctrl_if;

    logic                         can_fetch_inst; // Complete line waits in line_fetch
    logic                         clear_ibuffer;  // Drop buffered instructions
    logic [fetch_pkg::addr_w-1:0] line_pc;        // PC of the waiting line with offset
    logic                         fetch_inst;     // Line taken, next one wanted

    // PC side announces lines and flushes
    modport pc_side (
        output can_fetch_inst,
        output clear_ibuffer,
        output line_pc,
        input  fetch_inst
    );

    // Buffer side takes lines
    modport buf_side (
        input  can_fetch_inst,
        input  clear_ibuffer,
        input  line_pc,
        output fetch_inst
    );

endinterface

/* hw/inst_buffer.sv */
`timescale 1ns/10ps

module inst_buffer (
    input  logic                          clk,
    input  logic                          rst_n,

    ibuf_ctrl_if.buf_side                 ctrl,          // From pc_ctrl

    input  logic [fetch_pkg::beat_w*fetch_pkg::beats_per_line-1:0] line_data,

    output logic                          inst_valid,    // Instruction on offer
    output logic [fetch_pkg::inst_w-1:0]  inst_data,
    output logic [fetch_pkg::addr_w-1:0]  inst_pc,       // Address of inst_data
    input  logic                          inst_ready     // Consumer takes it
);

    logic [fetch_pkg::beat_w*fetch_pkg::beats_per_line-1:0] line_q;
    logic [fetch_pkg::addr_w-1:6]                   base_q;   // Line base address
    logic [$clog2(fetch_pkg::words_per_line)-1:0]   ptr;      // Current word
    logic                                           full;
    logic                                           fetch_q;
    logic                                           load;
    logic                                           fire;
    logic                                           last_word;

    // Take the waiting line only when empty
    assign load      = !full && ctrl.can_fetch_inst && !ctrl.clear_ibuffer;
    assign fire      = full && inst_ready;
    assign last_word = (int'(ptr) == fetch_pkg::words_per_line - 1);

    // Control path
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full    <= 1'b0;
            ptr     <= '0;
            fetch_q <= 1'b0;
        end else begin
            fetch_q <= 1'b0;
            if (ctrl.clear_ibuffer) begin
                full <= 1'b0;                                 // Redirect drops everything
            end else if (load) begin
                full    <= 1'b1;
                ptr     <= ctrl.line_pc[5:2];                 // Start at the line offset
                fetch_q <= 1'b1;                              // Ask for the next line
            end else if (fire) begin
                if (last_word) begin
                    full <= 1'b0;
                end else begin
                    ptr <= ptr + 1'b1;
                end
            end
        end
    end

    // Line payload and its base
    always_ff @(posedge clk) begin
        if (load) begin
            line_q <= line_data;
            base_q <= ctrl.line_pc[fetch_pkg::addr_w-1:6];
        end
    end

    assign ctrl.fetch_inst = fetch_q;

    // Output follows the buffer state directly
    assign inst_valid = full;
    assign inst_data  = line_q[ptr*fetch_pkg::inst_w +: fetch_pkg::inst_w];
    assign inst_pc    = {base_q, ptr, 2'b00};

endmodule

/* hw/line_fetch.sv */
`timescale 1ns/10ps

module line_fetch (
    input  logic                          clk,
    input  logic                          rst_n,

    fetch_req_if.mem_side                 req,             // From pc_ctrl

    output logic                          mem_req_valid,   // Index offered to memory
    output logic [fetch_pkg::index_w-1:0] mem_req_index,
    input  logic                          mem_req_ready,   // Memory takes the index
    input  logic                          mem_beat_valid,  // One beat returned
    input  logic [fetch_pkg::beat_w-1:0]  mem_beat_data,

    output logic [fetch_pkg::beat_w*fetch_pkg::beats_per_line-1:0] line_data
);

    fetch_pkg::lf_state_e                           state;
    logic [fetch_pkg::index_w-1:0]                  index_q;    // Latched request index
    logic [$clog2(fetch_pkg::beats_per_line)-1:0]   beat_cnt;   // Next beat slot
    logic                                           stale;      // Redirected while busy
    logic                                           done_q;
    logic                                           last_beat;
    logic [fetch_pkg::beat_w*fetch_pkg::beats_per_line-1:0] line_q;

    assign last_beat = mem_beat_valid
                       && (int'(beat_cnt) == fetch_pkg::beats_per_line - 1);

    // Control path
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= fetch_pkg::LF_IDLE;
            beat_cnt <= '0;
            stale    <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                fetch_pkg::LF_IDLE: begin
                    if (req.req_valid) begin
                        state <= fetch_pkg::LF_REQ;
                        stale <= 1'b0;                        // Fresh read
                    end
                end
                fetch_pkg::LF_REQ: begin
                    if (mem_req_ready) begin
                        state    <= fetch_pkg::LF_BEATS;
                        beat_cnt <= '0;
                    end
                    if (req.req_flush) stale <= 1'b1;
                end
                fetch_pkg::LF_BEATS: begin
                    if (mem_beat_valid) beat_cnt <= beat_cnt + 1'b1;
                    if (last_beat) begin
                        state  <= fetch_pkg::LF_IDLE;
                        done_q <= !stale && !req.req_flush;   // Late flush also kills it
                    end
                    if (req.req_flush) stale <= 1'b1;
                end
                default: state <= fetch_pkg::LF_IDLE;
            endcase
        end
    end

    // Index and line storage
    always_ff @(posedge clk) begin
        if (state == fetch_pkg::LF_IDLE && req.req_valid) begin
            index_q <= req.req_index;
        end
        if (state == fetch_pkg::LF_BEATS && mem_beat_valid && !stale && !req.req_flush) begin
            line_q[beat_cnt*fetch_pkg::beat_w +: fetch_pkg::beat_w] <= mem_beat_data;
        end
    end

    assign req.req_ready  = (state == fetch_pkg::LF_IDLE);   // One read at a time
    assign req.req_done   = done_q;
    assign mem_req_valid  = (state == fetch_pkg::LF_REQ);
    assign mem_req_index  = index_q;
    assign line_data      = line_q;

endmodule

/* hw/pc_ctrl.sv */
`timescale 1ns/10ps

module pc_ctrl (
    input  logic                         clk,
    input  logic                         rst_n,

    input  logic [fetch_pkg::addr_w-1:0] boot_addr,         // PC value out of reset
    input  logic                         interrupt_valid,   // Highest priority redirect
    input  logic [fetch_pkg::addr_w-1:0] interrupt_addr,
    input  logic                         branch_addr_valid, // Branch redirect
    input  logic [fetch_pkg::addr_w-1:0] branch_addr,

    fetch_req_if.pc_side                 req,               // Toward line_fetch
    ibuf_ctrl_if.pc_side                 ctrl               // Toward inst_buffer
);

    fetch_pkg::pc_state_e         state;
    logic [fetch_pkg::addr_w-1:0] pc;
    logic [fetch_pkg::addr_w-1:0] line_base;    // PC with line offset cleared
    logic [fetch_pkg::addr_w-1:0] next_line;    // Base of the following line
    logic                         req_valid_q;
    logic                         req_flush_q;
    logic                         can_fetch_q;
    logic                         clear_q;
    logic                         redirect;
    logic                         take_line;    // Buffer really consumed the waiting line

    assign line_base = {pc[fetch_pkg::addr_w-1:6], 6'b0};
    assign next_line = line_base + (fetch_pkg::addr_w)'(fetch_pkg::line_bytes);

    assign redirect  = interrupt_valid || branch_addr_valid;
    // A pulse that overlaps a flush belongs to a discarded line
    assign take_line = ctrl.fetch_inst && can_fetch_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc          <= boot_addr;
            state       <= fetch_pkg::PC_BOOT;
            req_valid_q <= 1'b0;
            req_flush_q <= 1'b0;
            can_fetch_q <= 1'b0;
            clear_q     <= 1'b0;
        end else begin
            req_flush_q <= 1'b0;                         // Both flush pulses last one cycle
            clear_q     <= 1'b0;
            if (redirect) begin
                // Interrupt wins over a branch in the same cycle
                pc          <= interrupt_valid ? interrupt_addr : branch_addr;
                state       <= fetch_pkg::PC_RUN;
                req_valid_q <= 1'b1;
                can_fetch_q <= 1'b0;                     // Waiting line is now stale
                req_flush_q <= 1'b1;
                clear_q     <= 1'b1;
            end else if (state == fetch_pkg::PC_BOOT) begin
                req_valid_q <= 1'b1;                     // First line request after reset
                state       <= fetch_pkg::PC_RUN;
            end else if (take_line) begin
                pc          <= next_line;                // Aligned sequential advance
                req_valid_q <= 1'b1;
                can_fetch_q <= 1'b0;
            end else if (req_valid_q && req.req_ready) begin
                req_valid_q <= 1'b0;                     // Index handed over
            end else if (req.req_done) begin
                can_fetch_q <= 1'b1;                     // Line complete in line_fetch
            end
        end
    end

    assign req.req_valid       = req_valid_q;
    assign req.req_index       = pc[21:3];               // 8-byte memory granularity
    assign req.req_flush       = req_flush_q;

    assign ctrl.can_fetch_inst = can_fetch_q;
    assign ctrl.clear_ibuffer  = clear_q;
    assign ctrl.line_pc        = pc;

endmodule
